/* rtl/u2_rx_pkg.sv */
/*
 * Receive path types, settings register offsets, LED source default
 * and the packet framer state encoding
 */
package u2_rx_pkg;

   // Settings bus, as seen after the clock crossing
   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;

   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      set_data_t data;
   } set_bus_t;

   typedef logic [13:0] adc_word_t;   // Raw converter word
   typedef logic [15:0] iq_t;         // Padded component
   typedef logic [31:0] sample_t;     // {I, Q}

   // One 36 bit line toward the packet router
   typedef struct packed {
      logic [1:0] spare;
      logic       eof;
      logic       sof;
      sample_t    data;
   } rx_line_t;

   typedef logic [15:0] rate_t;
   typedef logic [15:0] spp_t;

   typedef enum logic [1:0] {FR_IDLE, FR_HEADER, FR_SAMPLES} framer_state_t;

   localparam int SR_LED_SW  = 3;     // Misc block
   localparam int SR_LED_SRC = 6;
   localparam int SR_SPP     = 0;     // Control block
   localparam int SR_RUN     = 1;
   localparam int SR_CLEAR   = 3;
   localparam int SR_RATE    = 0;     // DSP block

   localparam logic [7:0] LED_SRC_AT_RESET = 8'b0000_0110;

endpackage

/* rtl/rx_settings.sv */
/*
 * Settings register decode for the receive path, clear pulse
 * and the hardware/software LED source mux
 */
`timescale 1ns/1ns

module rx_settings import u2_rx_pkg::*; #(
   parameter int BASE_MISC = 0,
   parameter int BASE_CTRL = 32,
   parameter int BASE_DSP  = 48
) (
   input  logic       dsp_clk,
   input  logic       por_rst,
   input  set_bus_t   set_bus_i,
   input  logic       overrun_i,
   output logic       run_o,
   output rate_t      rate_o,
   output spp_t       spp_o,
   output logic       clear_o,
   output logic [7:0] leds_o
);

   logic [7:0] led_sw;
   logic [7:0] led_src;
   logic [7:0] led_hw;
   logic       wr_led_sw, wr_led_src, wr_spp, wr_run, wr_clear, wr_rate;

   ////////////////////////////////////////
   // Address decode
   assign wr_led_sw  = set_bus_i.stb && (set_bus_i.addr == set_addr_t'(BASE_MISC + SR_LED_SW));
   assign wr_led_src = set_bus_i.stb && (set_bus_i.addr == set_addr_t'(BASE_MISC + SR_LED_SRC));
   assign wr_spp     = set_bus_i.stb && (set_bus_i.addr == set_addr_t'(BASE_CTRL + SR_SPP));
   assign wr_run     = set_bus_i.stb && (set_bus_i.addr == set_addr_t'(BASE_CTRL + SR_RUN));
   assign wr_clear   = set_bus_i.stb && (set_bus_i.addr == set_addr_t'(BASE_CTRL + SR_CLEAR));
   assign wr_rate    = set_bus_i.stb && (set_bus_i.addr == set_addr_t'(BASE_DSP + SR_RATE));

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         led_sw  <= '0;
         led_src <= LED_SRC_AT_RESET;
         run_o   <= 1'b0;
         rate_o  <= '0;
         spp_o   <= '0;
         clear_o <= 1'b0;
      end else begin
         if (wr_led_sw)
            led_sw <= set_bus_i.data[7:0];
         if (wr_led_src)
            led_src <= set_bus_i.data[7:0];
         if (wr_spp)
            spp_o <= set_bus_i.data[15:0];
         if (wr_run)
            run_o <= set_bus_i.data[0];
         if (wr_rate)
            rate_o <= set_bus_i.data[15:0];
         clear_o <= wr_clear;   // Data is ignored
      end
   end

   ////////////////////////////////////////
   // LEDs, a 1 in led_src selects hardware
   assign led_hw = {5'b0, overrun_i, run_o, 1'b0};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

   // Writers space clear strobes apart
   assert property (@(posedge dsp_clk) disable iff (por_rst) clear_o |=> !clear_o)
      else $error("clear_o held for more than one cycle");

endmodule

/* rtl/rx_sample_capture.sv */
/*
 * Sample capture with decimating strobe, ADC padding and sticky overrun
 */
`timescale 1ns/1ns

module rx_sample_capture import u2_rx_pkg::*; (
   input  logic      dsp_clk,
   input  logic      por_rst,
   input  logic      run_i,
   input  rate_t     rate_i,
   input  logic      clear_i,
   input  adc_word_t adc_a_i,
   input  adc_word_t adc_b_i,
   input  logic      fifo_full_i,
   output logic      wr_en_o,
   output sample_t   wr_sample_o,
   output logic      overrun_o
);

   logic  run_d1;    // Run as seen one cycle after the register
   rate_t cnt;
   logic  strobe;
   iq_t   i_pad;
   iq_t   q_pad;

   // Two low zero bits on each converter word
   assign i_pad       = {adc_a_i, 2'b00};
   assign q_pad       = {adc_b_i, 2'b00};
   assign wr_sample_o = {i_pad, q_pad};

   assign strobe  = run_d1 && !overrun_o && !clear_i && (cnt == '0);
   assign wr_en_o = strobe && !fifo_full_i;   // Full FIFO drops the sample

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         run_d1    <= 1'b0;
         cnt       <= '0;
         overrun_o <= 1'b0;
      end else begin
         run_d1 <= run_i;
         if (clear_i) begin
            overrun_o <= 1'b0;
            cnt       <= '0;
         end else begin
            if (strobe && fifo_full_i)
               overrun_o <= 1'b1;
            // Count down from rate and strobe at zero
            if (!run_d1 || overrun_o)
               cnt <= '0;   // First strobe right after run
            else if (cnt == '0)
               cnt <= rate_i;
            else
               cnt <= cnt - 1'b1;
         end
      end
   end

   assert property (@(posedge dsp_clk) disable iff (por_rst) fifo_full_i |-> !wr_en_o)
      else $error("write strobe into a full FIFO");

endmodule

/* rtl/sample_fifo.sv */
/*
 * Show-ahead circular sample buffer with synchronous clear
 */
`timescale 1ns/1ns

module sample_fifo import u2_rx_pkg::*; #(
   parameter int FIFO_AW = 4
) (
   input  logic    dsp_clk,
   input  logic    por_rst,
   input  logic    clear_i,
   input  logic    wr_en_i,
   input  sample_t wr_sample_i,
   input  logic    rd_en_i,
   output sample_t rd_sample_o,
   output logic    not_empty_o,
   output logic    full_o
);

   localparam int DEPTH = 2 ** FIFO_AW;

   sample_t            mem [DEPTH];
   logic [FIFO_AW-1:0] wr_ptr;
   logic [FIFO_AW-1:0] rd_ptr;
   logic [FIFO_AW:0]   count;    // Occupancy, 0 to DEPTH

   always_ff @(posedge dsp_clk) begin
      if (wr_en_i)
         mem[wr_ptr] <= wr_sample_i;
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst || clear_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en_i)
            wr_ptr <= wr_ptr + 1'b1;   // Wraps at DEPTH
         if (rd_en_i)
            rd_ptr <= rd_ptr + 1'b1;
         if (wr_en_i && !rd_en_i)
            count <= count + 1'b1;
         else if (rd_en_i && !wr_en_i)
            count <= count - 1'b1;
      end
   end

   assign rd_sample_o = mem[rd_ptr];   // Head visible without a read
   assign not_empty_o = (count != '0);
   assign full_o      = (count == (FIFO_AW+1)'(DEPTH));

   assert property (@(posedge dsp_clk) disable iff (por_rst) rd_en_i |-> not_empty_o)
      else $error("read from an empty FIFO");

   assert property (@(posedge dsp_clk) disable iff (por_rst) wr_en_i |-> !full_o)
      else $error("write into a full FIFO");

endmodule

/* rtl/rx_packet_framer.sv */
/*
 * Packet framer, header line then spp sample lines with eof on the last
 */
`timescale 1ns/1ns

module rx_packet_framer import u2_rx_pkg::*; (
   input  logic     dsp_clk,
   input  logic     por_rst,
   input  logic     clear_i,
   input  spp_t     spp_i,
   input  sample_t  rd_sample_i,
   input  logic     not_empty_i,
   output logic     rd_en_o,
   output rx_line_t line_o,
   output logic     line_valid_o,
   input  logic     line_ready_i
);

   framer_state_t state;
   spp_t          pkt_len;    // Latched per packet, never 0
   spp_t          remain;     // Sample lines still to send
   logic [15:0]   seq_num;
   logic          xfer;

   assign xfer = line_valid_o && line_ready_i;

   ////////////////////////////////////////
   // Line mux
   always_comb begin
      line_o       = '0;
      line_valid_o = 1'b0;
      rd_en_o      = 1'b0;
      case (state)
         FR_HEADER: begin
            line_o.sof   = 1'b1;
            line_o.data  = {seq_num, pkt_len};
            line_valid_o = 1'b1;
         end
         FR_SAMPLES: begin
            line_o.eof   = (remain == spp_t'(1));
            line_o.data  = rd_sample_i;
            line_valid_o = not_empty_i;
            rd_en_o      = not_empty_i && line_ready_i;   // Pop on accept
         end
         default: ;
      endcase
   end

   ////////////////////////////////////////
   // Sequencing
   always_ff @(posedge dsp_clk) begin
      if (por_rst || clear_i) begin
         state   <= FR_IDLE;
         pkt_len <= '0;
         remain  <= '0;
         seq_num <= '0;   // Partial packet is dropped
      end else begin
         case (state)
            FR_IDLE: begin
               if (not_empty_i) begin
                  pkt_len <= (spp_i == '0) ? spp_t'(1) : spp_i;
                  state   <= FR_HEADER;
               end
            end
            FR_HEADER: begin
               if (line_ready_i) begin
                  remain <= pkt_len;
                  state  <= FR_SAMPLES;
               end
            end
            FR_SAMPLES: begin
               if (xfer) begin
                  remain <= remain - 1'b1;
                  if (remain == spp_t'(1)) begin
                     seq_num <= seq_num + 1'b1;
                     state   <= FR_IDLE;
                  end
               end
            end
            default: state <= FR_IDLE;
         endcase
      end
   end

   // Held line stays put until the router takes it
   assert property (@(posedge dsp_clk) disable iff (por_rst || clear_i)
      line_valid_o && !line_ready_i |=> line_valid_o && $stable(line_o))
      else $error("line changed under back-pressure");

endmodule

/* rtl/u2_rx_core.sv */
/*
 * Receive path top, settings, capture, sample FIFO and framer
 */
`timescale 1ns/1ns

module u2_rx_core import u2_rx_pkg::*; #(
   parameter int BASE_MISC = 0,
   parameter int BASE_CTRL = 32,
   parameter int BASE_DSP  = 48,
   parameter int FIFO_AW   = 4
) (
   input  logic       dsp_clk,
   input  logic       por_rst,
   input  set_bus_t   set_bus_i,
   input  adc_word_t  adc_a_i,
   input  adc_word_t  adc_b_i,
   output rx_line_t   line_o,
   output logic       line_valid_o,
   input  logic       line_ready_i,
   output logic       overrun_o,
   output logic [7:0] leds_o
);

   logic    run, clear;
   rate_t   rate;
   spp_t    spp;
   logic    wr_en, fifo_full, not_empty, rd_en;
   sample_t wr_sample, rd_sample;

   ////////////////////////////////////////
   // Settings and LEDs
   rx_settings #(.BASE_MISC(BASE_MISC), .BASE_CTRL(BASE_CTRL), .BASE_DSP(BASE_DSP))
   rx_settings_i (
      .dsp_clk, .por_rst, .set_bus_i, .overrun_i(overrun_o),
      .run_o(run), .rate_o(rate), .spp_o(spp), .clear_o(clear), .leds_o);

   ////////////////////////////////////////
   // Capture, buffer, framing
   rx_sample_capture rx_sample_capture_i (
      .dsp_clk, .por_rst, .run_i(run), .rate_i(rate), .clear_i(clear),
      .adc_a_i, .adc_b_i, .fifo_full_i(fifo_full),
      .wr_en_o(wr_en), .wr_sample_o(wr_sample), .overrun_o);

   sample_fifo #(.FIFO_AW(FIFO_AW)) sample_fifo_i (
      .dsp_clk, .por_rst, .clear_i(clear),
      .wr_en_i(wr_en), .wr_sample_i(wr_sample),
      .rd_en_i(rd_en), .rd_sample_o(rd_sample),
      .not_empty_o(not_empty), .full_o(fifo_full));

   rx_packet_framer rx_packet_framer_i (
      .dsp_clk, .por_rst, .clear_i(clear), .spp_i(spp),
      .rd_sample_i(rd_sample), .not_empty_i(not_empty), .rd_en_o(rd_en),
      .line_o, .line_valid_o, .line_ready_i);   // Toward the packet router

endmodule

/* dv/rx_tb_checks.svh */
/*
 * Concurrent checks on the receive path outputs, test result counting
 */
`ifndef RX_TB_CHECKS_SVH
`define RX_TB_CHECKS_SVH

   string test_name    = "startup";
   int    test_errs    = 0;
   int    total_errs   = 0;
   int    tests_passed = 0;
   int    tests_failed = 0;

   // Wrong value, logged against the running test
   task automatic flag_mismatch(input string what, input logic [63:0] expected,
                                input logic [63:0] actual);
      $display("** Error %s: %s expected %0h actual %0h", test_name, what, expected, actual);
      test_errs++;
      total_errs++;
   endtask

   task automatic finish_test();
      if (test_errs == 0) begin
         tests_passed++;
         $display("test %-18s passed", test_name);
      end else begin
         tests_failed++;
         $display("test %-18s failed with %0d errors", test_name, test_errs);
      end
      test_errs = 0;
   endtask

   // {I, Q} as the padding and b = a + 1 imply
   function automatic sample_t pair_from_i(input iq_t i);
      iq_t i_clean;
      i_clean = {i[15:2], 2'b00};
      return {i_clean, i_clean + 16'd4};
   endfunction

   ////////////////////////////////////////
   // Packet stream
   assert property (@(posedge dsp_clk) disable iff (por_rst)
      xfer && exp_pos == '0 |-> line == {4'b0001, exp_seq, exp_spp})
      else flag_mismatch("header line", {4'b0001, $sampled(exp_seq), $sampled(exp_spp)},
                         $sampled(line));

   assert property (@(posedge dsp_clk) disable iff (por_rst)
      xfer && exp_pos != '0 |-> line[35:32] == {2'b00, exp_pos == exp_spp, 1'b0})
      else flag_mismatch("sample flags", {2'b00, $sampled(exp_pos) == $sampled(exp_spp), 1'b0},
                         $sampled(line[35:32]));

   assert property (@(posedge dsp_clk) disable iff (por_rst)
      xfer && exp_pos != '0 |-> line.data == pair_from_i(line.data[31:16]))
      else flag_mismatch("sample pair", pair_from_i($sampled(line.data[31:16])),
                         $sampled(line.data));

   assert property (@(posedge dsp_clk) disable iff (por_rst)
      xfer && exp_pos != '0 && have_prev |-> line.data[31:16] == next_i)
      else flag_mismatch("sample step", $sampled(next_i), $sampled(line.data[31:16]));

   // Held line, valid included
   assert property (@(posedge dsp_clk) disable iff (por_rst)
      check_hold && line_valid && !line_ready |=> line_valid && line == last_line)
      else flag_mismatch("held line", {1'b1, $sampled(last_line)},
                         {$sampled(line_valid), $sampled(line)});

   ////////////////////////////////////////
   // Status and LEDs
   assert property (@(posedge dsp_clk) disable iff (por_rst)
      check_reset |-> !line_valid && !overrun && leds == '0)
      else flag_mismatch("valid, overrun, leds", 64'h0,
                         {$sampled(line_valid), $sampled(overrun), $sampled(leds)});

   assert property (@(posedge dsp_clk) disable iff (por_rst) check_leds |-> leds == exp_leds)
      else flag_mismatch("leds", $sampled(exp_leds), $sampled(leds));

   assert property (@(posedge dsp_clk) disable iff (por_rst)
      check_overrun |-> overrun && leds[2:1] == 2'b11)
      else flag_mismatch("overrun, leds[2:1]", 64'h7, {$sampled(overrun), $sampled(leds[2:1])});

   assert property (@(posedge dsp_clk) disable iff (por_rst) check_cleared |-> !overrun)
      else flag_mismatch("overrun after clear", 64'h0, $sampled(overrun));

`endif

/* dv/u2_rx_core_tb.sv */
/*
 * Receive path testbench with clock, reset, stimulus,
 * reference counters and timeout
 */
`timescale 1ns/1ns

module u2_rx_core_tb import u2_rx_pkg::*; ();

   localparam int MISC_BASE = 0;
   localparam int CTRL_BASE = 32;
   localparam int DSP_BASE  = 48;
   localparam int N_PACKETS = 3;
   // Reset, leds, packets, rate 3, back-pressure, overrun
   localparam int TEST_CYCLES = 10 + 12 + 60 + 90 + 140 + 80;
   localparam int CYCLE_LIMIT = 2 * TEST_CYCLES + 100;

   logic       dsp_clk = 1'b0;
   logic       por_rst = 1'b1;
   set_bus_t   set_bus = '0;
   adc_word_t  adc_a = 14'd0;
   adc_word_t  adc_b = 14'd1;
   logic       line_ready = 1'b0;
   rx_line_t   line, last_line;
   logic       line_valid, overrun;
   logic [7:0] leds;
   int         cycles = 0;

   // Reference model state
   logic        xfer, have_prev;
   spp_t        exp_spp = '0;
   rate_t       exp_rate = '0;
   spp_t        exp_pos;          // 0 while a header is due
   logic [15:0] exp_seq;
   iq_t         prev_i, next_i;
   logic [7:0]  exp_leds = '0;
   logic        ref_reset = 1'b0;
   logic        check_reset = 1'b0, check_leds = 1'b0, check_hold = 1'b0;
   logic        check_overrun = 1'b0, check_cleared = 1'b0;

   u2_rx_core #(
      .BASE_MISC(MISC_BASE), .BASE_CTRL(CTRL_BASE), .BASE_DSP(DSP_BASE), .FIFO_AW(4)
   ) u2_rx_core_i (
      .dsp_clk, .por_rst, .set_bus_i(set_bus), .adc_a_i(adc_a), .adc_b_i(adc_b),
      .line_o(line), .line_valid_o(line_valid), .line_ready_i(line_ready),
      .overrun_o(overrun), .leds_o(leds));

   always #2 dsp_clk = ~dsp_clk;

   always @(negedge dsp_clk) begin
      adc_a <= adc_a + 14'd1;   // Free running converter
      adc_b <= adc_a + 14'd2;
   end

   ////////////////////////////////////////
   // Reference counters advanced per accepted line
   assign xfer   = line_valid && line_ready;
   assign next_i = prev_i + {exp_rate[13:0], 2'b00} + 16'd4;   // 4 * (rate + 1)

   always @(posedge dsp_clk) begin
      last_line <= line;
      if (por_rst || ref_reset) begin
         exp_pos   <= '0;
         exp_seq   <= '0;
         prev_i    <= '0;
         have_prev <= 1'b0;
      end else if (xfer) begin
         if (exp_pos == '0) begin
            exp_pos <= spp_t'(1);
         end else begin
            prev_i    <= line.data[31:16];
            have_prev <= 1'b1;
            if (exp_pos == exp_spp) begin
               exp_pos <= '0;
               exp_seq <= exp_seq + 1'b1;
            end else begin
               exp_pos <= exp_pos + 1'b1;
            end
         end
      end
   end

   `include "rx_tb_checks.svh"

   always @(posedge dsp_clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout: %s did not finish within %0d cycles", test_name, CYCLE_LIMIT);
         $display("Done: errors found");
         $finish;
      end
   end

   task automatic write_setting(input int addr, input int data);
      @(negedge dsp_clk);
      set_bus = '{stb: 1'b1, addr: set_addr_t'(addr), data: set_data_t'(data)};
      @(negedge dsp_clk);
      set_bus = '0;
   endtask

   task automatic start_stream(input int rate, input logic ready);
      exp_spp    = spp_t'(4);
      exp_rate   = rate_t'(rate);
      line_ready = ready;
      write_setting(CTRL_BASE + SR_SPP, 4);
      write_setting(DSP_BASE + SR_RATE, rate);
      write_setting(CTRL_BASE + SR_RUN, 1);
   endtask

   task automatic wait_packets(input int n);
      while (exp_seq != 16'(n))
         @(negedge dsp_clk);
   endtask

   task automatic stop_and_clear();
      line_ready = 1'b0;
      check_hold = 1'b0;
      write_setting(CTRL_BASE + SR_RUN, 0);
      write_setting(CTRL_BASE + SR_CLEAR, 0);
      @(negedge dsp_clk);   // Clear has landed
      ref_reset = 1'b1;
      @(negedge dsp_clk);
      ref_reset = 1'b0;
   endtask

   initial begin
      void'($urandom(5));   // Fixed seed for the ready pattern
      repeat (5) @(negedge dsp_clk);
      por_rst = 1'b0;

      test_name = "reset_state";
      @(negedge dsp_clk);
      check_reset = 1'b1;
      @(negedge dsp_clk);
      check_reset = 1'b0;
      finish_test();

      test_name = "sw_leds";
      exp_leds  = 8'h5a;
      write_setting(MISC_BASE + SR_LED_SW, 'h5a);
      write_setting(MISC_BASE + SR_LED_SRC, 0);
      check_leds = 1'b1;
      @(negedge dsp_clk);
      check_leds = 1'b0;
      write_setting(MISC_BASE + SR_LED_SRC, LED_SRC_AT_RESET);
      finish_test();

      test_name = "packet_format";
      start_stream(0, 1'b1);
      wait_packets(N_PACKETS);
      stop_and_clear();
      finish_test();

      test_name = "sample_content_r3";
      start_stream(3, 1'b1);
      wait_packets(N_PACKETS);
      stop_and_clear();
      finish_test();

      test_name = "back_pressure";
      start_stream(3, 1'b0);
      check_hold = 1'b1;
      while (exp_seq != 16'(N_PACKETS)) begin
         @(negedge dsp_clk);
         line_ready = 1'($urandom());
      end
      stop_and_clear();
      finish_test();

      ////////////////////////////////////////
      // FIFO fills behind a stalled router
      test_name = "overrun_clear";
      start_stream(0, 1'b1);
      wait_packets(1);   // Sequence moves off 0 before the stall
      line_ready = 1'b0;
      while (!overrun)
         @(negedge dsp_clk);
      check_overrun = 1'b1;
      @(negedge dsp_clk);
      check_overrun = 1'b0;
      write_setting(CTRL_BASE + SR_CLEAR, 0);
      @(negedge dsp_clk);
      ref_reset     = 1'b1;   // Sequence restarts at 0
      check_cleared = 1'b1;
      line_ready    = 1'b1;
      @(negedge dsp_clk);
      ref_reset     = 1'b0;
      check_cleared = 1'b0;
      wait_packets(1);
      stop_and_clear();
      finish_test();

      $display("Tests: %0d passed, %0d failed, %0d errors",
               tests_passed, tests_failed, total_errs);
      if (total_errs == 0 && tests_failed == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

/* sources.f */
+incdir+dv
rtl/u2_rx_pkg.sv
rtl/rx_settings.sv
rtl/rx_sample_capture.sv
rtl/sample_fifo.sv
rtl/rx_packet_framer.sv
rtl/u2_rx_core.sv
dv/u2_rx_core_tb.sv

/* Bender.yml */
package:
  name: u2_rx_core

sources:
  - rtl/u2_rx_pkg.sv
  - rtl/rx_settings.sv
  - rtl/rx_sample_capture.sv
  - rtl/sample_fifo.sv
  - rtl/rx_packet_framer.sv
  - rtl/u2_rx_core.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/u2_rx_core_tb.sv
